// File: src.f
+incdir+dv
rtl/vic_pkg.sv
rtl/vic_phase_gen.sv
rtl/vic_raster_counter.sv
rtl/vic_badline_ba.sv
rtl/vic_raster_irq.sv
rtl/vic_registers.sv
rtl/vic_timing_top.sv
dv/tb_vic_timing.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_vic_timing \
    && ./obj_dir/Vtb_vic_timing > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

// File: dv/tb_vic_tasks.svh
// ----------------------------------------
// clocking, waits and bus access
// ----------------------------------------
// one dot4x step, lands 1 ns after the rising edge
task automatic tick();
    @(posedge clk_dot4x);
    #1;
    tick_cnt++;
endtask

task automatic apply_reset(chip_t c);
    rst = 1'b1;
    chip = c;
    bus.ce_n = 1'b1;
    bus.rw = 1'b1;
    repeat (4) tick();
    rst = 1'b0;
endtask

// a half phase is 16 ticks, so 40 is plenty
task automatic wait_phi(logic lvl);
    int n;
    n = 0;
    while (clk_phi !== lvl && n < 40) begin
        tick();
        n++;
    end
    if (clk_phi !== lvl) begin
        $display("ERROR in %s: timeout waiting for clk_phi_o = %0b", test_name, lvl);
        errors++;
    end
endtask

// returns on the first tick of a phi-low half, the start of a phi cycle
task automatic wait_phi_fall();
    wait_phi(1'b1);
    wait_phi(1'b0);
endtask

task automatic wait_irq(logic lvl, int limit, output int at);
    int n;
    n = 0;
    while (irq !== lvl && n < limit) begin
        tick();
        n++;
    end
    at = tick_cnt;
    if (irq !== lvl) begin
        $display("ERROR in %s: timeout waiting for irq_o = %0b", test_name, lvl);
        errors++;
    end
endtask

// bus held for one whole phi cycle, the dut takes it at the dav tick
task automatic bus_write(logic [5:0] addr, logic [7:0] data);
    wait_phi_fall();
    bus = '{ce_n: 1'b0, rw: 1'b0, addr: addr, wdata: data};
    wait_phi_fall();
    bus.ce_n = 1'b1;
    bus.rw = 1'b1;
endtask

task automatic bus_read(logic [5:0] addr, output logic [7:0] data);
    wait_phi_fall();
    bus = '{ce_n: 1'b0, rw: 1'b1, addr: addr, wdata: 8'h00};
    wait_phi(1'b1);
    // dav is tick 11 of the phi-high half
    repeat (11) tick();
    data = dbo;
    wait_phi_fall();
    bus.ce_n = 1'b1;
endtask

// frame length in dot4x ticks, 4 ticks per pixel
function automatic int frame_ticks(chip_t c);
    case (c)
        CHIP_6567R8:   return 4 * 520 * 263;
        CHIP_6567R56A: return 4 * 512 * 262;
        default:       return 4 * 504 * 312;
    endcase
endfunction

// character rows start on lines 48..247 whose low bits match yscroll
function automatic int expected_badlines(int yscroll);
    int cnt;
    cnt = 0;
    for (int l = 48; l < 248; l++) begin
        if (l % 8 == yscroll) begin
            cnt++;
        end
    end
    return cnt;
endfunction

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic reset_state();
    int t0;
    int t1;
    int t2;
    begin_test("reset_state");
    apply_reset(CHIP_6569);
    compare_byte("irq_o", 8'h00, {7'h00, irq});
    compare_byte("ba_o", 8'h01, {7'h00, ba});
    compare_byte("aec_o", 8'h00, {7'h00, aec});
    repeat (4) begin
        wait_phi_fall();
        t0 = tick_cnt;
        wait_phi(1'b1);
        t1 = tick_cnt;
        wait_phi(1'b0);
        t2 = tick_cnt;
        compare_num("phi high ticks", 16, t2 - t1);
        compare_num("phi period", 32, t2 - t0);
    end
    end_test();
endtask

task automatic register_readback();
    logic [7:0] v;
    logic [7:0] rd;
    logic [5:0] unused_addr [3];
    begin_test("register_readback");
    apply_reset(CHIP_6569);
    unused_addr = '{6'h00, 6'h2F, 6'h3F};
    // all of this stays in the first lines, so line bit 8 reads 0
    for (int i = 0; i < 4; i++) begin
        v = 8'($random(seed));
        bus_write(REG_BORDER, v);
        bus_read(REG_BORDER, rd);
        compare_byte("border", {4'hF, v[3:0]}, rd);
        v = 8'($random(seed));
        bus_write(REG_IRQ_EN, v);
        bus_read(REG_IRQ_EN, rd);
        compare_byte("irq enable", {7'h7F, v[0]}, rd);
        v = 8'($random(seed));
        bus_write(REG_CTRL1, v);
        bus_read(REG_CTRL1, rd);
        compare_byte("ctrl1", {1'b0, v[6:0]}, rd);
    end
    for (int i = 0; i < 3; i++) begin
        bus_read(unused_addr[i], rd);
        compare_byte($sformatf("unused 0x%0h", unused_addr[i]), 8'hFF, rd);
    end
    end_test();
endtask

task automatic irq_period_per_chip();
    chip_t chips [3];
    int t_first;
    int t_next;
    begin_test("irq_period");
    chips = '{CHIP_6567R8, CHIP_6567R56A, CHIP_6569};
    for (int k = 0; k < 3; k++) begin
        apply_reset(chips[k]);
        bus_write(REG_RASTER, 8'd100);
        bus_write(REG_CTRL1, 8'h00);
        // line 0 matched the reset compare value, drop that latch
        bus_write(REG_IRQ, 8'h01);
        bus_write(REG_IRQ_EN, 8'h01);
        wait_irq(1'b1, frame_ticks(chips[k]) + 4000, t_first);
        bus_write(REG_IRQ, 8'h01);
        wait_irq(1'b0, 64, t_next);
        wait_irq(1'b1, frame_ticks(chips[k]) + 4000, t_next);
        compare_num($sformatf("irq interval %s", chips[k].name()),
                    frame_ticks(chips[k]), t_next - t_first);
    end
    end_test();
endtask

task automatic erst_gating();
    logic [7:0] rd;
    int polls;
    int t;
    begin_test("erst_gating");
    apply_reset(CHIP_6569);
    bus_write(REG_RASTER, 8'd100);
    bus_write(REG_CTRL1, 8'h00);
    bus_write(REG_IRQ, 8'h01);
    bus_write(REG_IRQ_EN, 8'h00);
    // poll the latch until line 100 comes round, about 3200 reads
    polls = 0;
    bus_read(REG_IRQ, rd);
    while (rd[0] == 1'b0 && polls < 12000) begin
        compare_byte("irq_o while polling", 8'h00, {7'h00, irq});
        bus_read(REG_IRQ, rd);
        polls++;
    end
    ensure(rd[0] == 1'b1, "raster latch never set with erst clear");
    compare_byte("irq reg, erst clear", 8'h7F, rd);
    compare_byte("irq_o, erst clear", 8'h00, {7'h00, irq});
    bus_write(REG_IRQ_EN, 8'h01);
    wait_irq(1'b1, 64, t);
    bus_read(REG_IRQ, rd);
    compare_byte("irq reg, erst set", 8'hFF, rd);
    bus_write(REG_IRQ, 8'h01);
    wait_irq(1'b0, 64, t);
    bus_read(REG_IRQ, rd);
    compare_byte("irq reg after clear", 8'h7E, rd);
    end_test();
endtask

// one ba window per badline, so falls over a frame count the lines
task automatic count_ba_falls(logic [7:0] ctrl1, output int falls);
    logic ba_prev;
    apply_reset(CHIP_6569);
    bus_write(REG_CTRL1, ctrl1);
    falls = 0;
    ba_prev = ba;
    for (int n = 0; n < frame_ticks(CHIP_6569); n++) begin
        tick();
        if (ba_prev && !ba) begin
            falls++;
        end
        ba_prev = ba;
    end
endtask

task automatic badline_count();
    int falls;
    begin_test("badline_count");
    // den set, yscroll 3
    count_ba_falls(8'h13, falls);
    compare_num("ba lines, den set", expected_badlines(3), falls);
    count_ba_falls(8'h03, falls);
    compare_num("ba lines, den clear", 0, falls);
    end_test();
endtask

task automatic aec_steal();
    int fall_tick;
    int rise_tick;
    int falls;
    logic ba_prev;
    logic phi_prev;
    begin_test("aec_steal");
    apply_reset(CHIP_6569);
    bus_write(REG_CTRL1, 8'h13);
    falls = 0;
    fall_tick = 0;
    rise_tick = 0;
    ba_prev = ba;
    phi_prev = clk_phi;
    for (int n = 0; n < frame_ticks(CHIP_6569); n++) begin
        tick();
        if (ba_prev && !ba) begin
            falls++;
            fall_tick = tick_cnt;
        end
        if (!phi_prev && clk_phi) begin
            rise_tick = tick_cnt;
        end
        ensure(clk_phi || !aec, "aec_o high while clk_phi_o low");
        // phi-high halves starting three phi cycles after the fall belong to the vic
        if (clk_phi && !ba && (rise_tick - fall_tick >= 3 * 32)) begin
            ensure(!aec, "aec_o high in a phi-high half taken by the character fetch");
        end
        if (clk_phi && ba) begin
            ensure(aec, "aec_o low in a phi-high half with ba_o high");
        end
        ba_prev = ba;
        phi_prev = clk_phi;
    end
    ensure(falls > 0, "ba_o never fell, no steal window was seen");
    end_test();
endtask

// File: dv/tb_vic_timing.sv
`timescale 1ns/1ns

module tb_vic_timing;
    import vic_pkg::*;

    logic       clk_dot4x;
    logic       rst;
    chip_t      chip;
    cpu_bus_t   bus;
    logic [7:0] dbo;
    logic       clk_phi;
    logic       ba;
    logic       aec;
    logic       irq;

    // run bookkeeping
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_errors_at_start;
    int     tick_cnt;
    string  test_name;
    integer seed;

    vic_timing_top i_vic_timing_top (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip),
        .bus_i     (bus),
        .dbo_o     (dbo),
        .clk_phi_o (clk_phi),
        .ba_o      (ba),
        .aec_o     (aec),
        .irq_o     (irq)
    );

    // 4 ns dot4x clock
    initial begin
        clk_dot4x = 1'b0;
        forever begin
            #2 clk_dot4x = ~clk_dot4x;
        end
    end

    // ----------------------------------------
    // checks and per-test reporting
    // ----------------------------------------
    task automatic compare_byte(string what, logic [7:0] expected, logic [7:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_num(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // failures that are not a wrong value
    task automatic ensure(bit cond, string what);
        assert (cond) else begin
            $display("ERROR in %s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != test_errors_at_start) begin
            tests_failed++;
        end
        $display("[%s] finished, %0d error(s)", test_name, errors - test_errors_at_start);
    endtask

    `include "tb_vic_tasks.svh"

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        rst = 1'b1;
        chip = CHIP_6569;
        bus = '{ce_n: 1'b1, rw: 1'b1, addr: 6'h00, wdata: 8'h00};
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors_at_start = 0;
        tick_cnt = 0;
        test_name = "";
        seed = 32'haf8c;

        reset_state();
        register_readback();
        irq_period_per_chip();
        erst_gating();
        badline_count();
        aec_steal();

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/vic_timing_top.sv
`timescale 1ns/1ns

module vic_timing_top (
    input  logic              clk_dot4x,
    input  logic              rst,
    input  vic_pkg::chip_t    chip_i,
    input  vic_pkg::cpu_bus_t bus_i,
    output logic [7:0]        dbo_o,
    output logic              clk_phi_o,
    output logic              ba_o,
    output logic              aec_o,
    output logic              irq_o
);
    import vic_pkg::*;

    phase_t      phase;
    raster_pos_t raster;
    vic_ctrl_t   ctrl;
    logic        irst;
    logic        irst_clr;

    // phi, dot strobe and half-phase position
    vic_phase_gen i_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    vic_raster_counter i_raster_counter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .raster_o  (raster)
    );

    // character fetch stalls
    vic_badline_ba i_badline_ba (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .raster_i  (raster),
        .ctrl_i    (ctrl),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    vic_raster_irq i_raster_irq (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .phase_i    (phase),
        .raster_i   (raster),
        .ctrl_i     (ctrl),
        .irst_clr_i (irst_clr),
        .irst_o     (irst),
        .irq_o      (irq_o)
    );

    // cpu side
    vic_registers i_registers (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .phase_i    (phase),
        .raster_i   (raster),
        .bus_i      (bus_i),
        .irst_i     (irst),
        .dbo_o      (dbo_o),
        .ctrl_o     (ctrl),
        .irst_clr_o (irst_clr)
    );

    assign clk_phi_o = phase.clk_phi;

endmodule

// File: rtl/vic_registers.sv
`timescale 1ns/1ns

module vic_registers (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::phase_t      phase_i,
    input  vic_pkg::raster_pos_t raster_i,
    input  vic_pkg::cpu_bus_t    bus_i,
    input  logic                 irst_i,
    output logic [7:0]           dbo_o,
    output vic_pkg::vic_ctrl_t   ctrl_o,
    output logic                 irst_clr_o
);
    import vic_pkg::*;

    logic wr_stb;
    logic irq_state;

    // ----------------------------------------
    // write side
    // ----------------------------------------
    // one write per phi cycle taken at the dav tick
    assign wr_stb = !bus_i.ce_n && !bus_i.rw && phase_i.clk_phi &&
                    (phase_i.phase_pos == PHASE_DAV);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl_o     <= '0;
            irst_clr_o <= 1'b0;
        end else begin
            // ack pulse for the raster latch
            irst_clr_o <= wr_stb && (bus_i.addr == REG_IRQ) && bus_i.wdata[0];
            if (wr_stb) begin
                case (bus_i.addr)
                    REG_CTRL1: begin
                        ctrl_o.yscroll       <= bus_i.wdata[2:0];
                        ctrl_o.rsel          <= bus_i.wdata[3];
                        ctrl_o.den           <= bus_i.wdata[4];
                        ctrl_o.bmm           <= bus_i.wdata[5];
                        ctrl_o.ecm           <= bus_i.wdata[6];
                        // bit 7 is the ninth compare bit
                        ctrl_o.raster_cmp[8] <= bus_i.wdata[7];
                    end
                    REG_RASTER: begin
                        ctrl_o.raster_cmp[7:0] <= bus_i.wdata;
                    end
                    REG_IRQ_EN: begin
                        ctrl_o.erst <= bus_i.wdata[0];
                    end
                    REG_BORDER: begin
                        ctrl_o.border <= bus_i.wdata[3:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // read side
    // ----------------------------------------
    assign irq_state = irst_i && ctrl_o.erst;

    // reads show the delayed line that the compare also uses
    always_comb begin
        dbo_o = 8'hFF;
        if (!bus_i.ce_n) begin
            case (bus_i.addr)
                REG_CTRL1: begin
                    dbo_o = {raster_i.raster_line_d[8], ctrl_o.ecm, ctrl_o.bmm,
                             ctrl_o.den, ctrl_o.rsel, ctrl_o.yscroll};
                end
                REG_RASTER: begin
                    dbo_o = raster_i.raster_line_d[7:0];
                end
                REG_IRQ: begin
                    dbo_o = {irq_state, 6'b111111, irst_i};
                end
                REG_IRQ_EN: begin
                    dbo_o = {7'b1111111, ctrl_o.erst};
                end
                REG_BORDER: begin
                    dbo_o = {4'hF, ctrl_o.border};
                end
                default: begin
                    dbo_o = 8'hFF;
                end
            endcase
        end
    end

endmodule

// File: rtl/vic_raster_irq.sv
`timescale 1ns/1ns

module vic_raster_irq (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::phase_t      phase_i,
    input  vic_pkg::raster_pos_t raster_i,
    input  vic_pkg::vic_ctrl_t   ctrl_i,
    input  logic                 irst_clr_i,
    output logic                 irst_o,
    output logic                 irq_o
);
    import vic_pkg::*;

    logic [8:0] cmp_d;
    logic       triggered;
    logic       cmp_tick;

    assign cmp_tick = !phase_i.clk_phi && (phase_i.phase_pos == PHASE_IRQ);

    // compare value lines up with raster_line_d changes
    always_ff @(posedge clk_dot4x) begin
        cmp_d <= ctrl_i.raster_cmp;
    end

    // raise once per matching line and rearm when the match ends
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst_o    <= 1'b0;
            triggered <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            if (raster_i.raster_line_d == cmp_d) begin
                if (cmp_tick && !triggered) begin
                    triggered <= 1'b1;
                    irst_o    <= 1'b1;
                end
            end else begin
                triggered <= 1'b0;
            end
            // latch stays set until the cpu acknowledges it
            if (irst_clr_i) begin
                irst_o <= 1'b0;
            end
            irq_o <= irst_o && ctrl_i.erst;
        end
    end

endmodule

// File: rtl/vic_badline_ba.sv
`timescale 1ns/1ns

module vic_badline_ba (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::phase_t      phase_i,
    input  vic_pkg::raster_pos_t raster_i,
    input  vic_pkg::vic_ctrl_t   ctrl_i,
    output logic                 ba_o,
    output logic                 aec_o
);
    import vic_pkg::*;

    logic allow_bl;
    logic allow_next;
    logic badline;
    logic line_check;
    logic in_char_win;
    logic phi_high_end;
    logic ba1;
    logic ba2;
    logic ba3;

    // one evaluation per cycle early in the phi-low half
    assign line_check = !phase_i.clk_phi && (phase_i.phase_pos == 4'd1);

    // ----------------------------------------
    // badline allow window
    // ----------------------------------------
    // raster_line_d also catches den set in the last cycle of line 48
    always_comb begin
        allow_next = allow_bl;
        if (ctrl_i.den && (raster_i.raster_line == BADLINE_FIRST ||
                           raster_i.raster_line_d == BADLINE_FIRST)) begin
            allow_next = 1'b1;
        end
        if (raster_i.raster_line == BADLINE_LAST) begin
            allow_next = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bl <= 1'b0;
            badline  <= 1'b0;
        end else if (line_check) begin
            allow_bl <= allow_next;
            badline  <= allow_next &&
                        (raster_i.raster_line[2:0] == ctrl_i.yscroll) &&
                        (raster_i.raster_line >= BADLINE_FIRST) &&
                        (raster_i.raster_line < BADLINE_LAST);
        end
    end

    // ----------------------------------------
    // ba and aec
    // ----------------------------------------
    assign in_char_win = (raster_i.cycle_num >= BA_CHAR_FIRST_CYCLE) &&
                         (raster_i.cycle_num <= BA_CHAR_LAST_CYCLE);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b1;
        end else begin
            ba_o <= !(badline && in_char_win);
        end
    end

    assign phi_high_end = phase_i.clk_phi && (phase_i.phase_pos == 4'd15);

    // ba3 stays high until ba has been low at three phi-high ends
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba1 <= 1'b1;
            ba2 <= 1'b1;
            ba3 <= 1'b1;
        end else if (phi_high_end) begin
            ba1 <= ba_o;
            ba2 <= ba1 | ba_o;
            ba3 <= ba2 | ba_o;
        end
    end

    // cpu keeps phi-high halves until the vic steals them
    assign aec_o = phase_i.clk_phi && (ba_o || ba3);

    a_aec_phi: assert property (@(posedge clk_dot4x) disable iff (rst)
        !phase_i.clk_phi |-> !aec_o)
        else $error("aec high in a phi-low half");

endmodule

// File: rtl/vic_raster_counter.sv
`timescale 1ns/1ns

module vic_raster_counter (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_pkg::chip_t       chip_i,
    input  vic_pkg::phase_t      phase_i,
    output vic_pkg::raster_pos_t raster_o
);
    import vic_pkg::*;

    chip_limits_t limits;
    logic [9:0]   raster_x;
    logic [8:0]   raster_line;
    logic [8:0]   raster_line_d;
    logic         x_wrap;
    logic         phi_cycle_end;

    assign limits = chip_limits(chip_i);

    // last pixel of the line
    assign x_wrap = (raster_x == limits.raster_x_max);

    // last tick of the phi-high half, the next tick starts a new cycle
    assign phi_cycle_end = phase_i.clk_phi && (phase_i.phase_pos == 4'd15);

    // ----------------------------------------
    // pixel and line counters
    // ----------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= 10'd0;
            raster_line <= 9'd0;
        end else if (phase_i.dot_last) begin
            if (x_wrap) begin
                raster_x <= 10'd0;
                // line steps together with the x wrap
                if (raster_line == limits.raster_y_max) begin
                    raster_line <= 9'd0;
                end else begin
                    raster_line <= raster_line + 9'd1;
                end
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end
    end

    // line seen by compare and readback, one phi cycle behind
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line_d <= 9'd0;
        end else if (phi_cycle_end) begin
            raster_line_d <= raster_line;
        end
    end

    assign raster_o.raster_x      = raster_x;
    // 8 pixels per phi cycle
    assign raster_o.cycle_num     = raster_x[9:3];
    assign raster_o.raster_line   = raster_line;
    assign raster_o.raster_line_d = raster_line_d;

    a_x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x <= limits.raster_x_max)
        else $error("raster_x beyond the chip limit");

endmodule

// File: rtl/vic_phase_gen.sv
`timescale 1ns/1ns

module vic_phase_gen (
    input  logic            clk_dot4x,
    input  logic            rst,
    output vic_pkg::phase_t phase_o
);

    // phi pattern with the live phi level in bit 0
    logic [31:0] phi_sr;
    // dot strobe where bit 3 marks the last tick of a pixel
    logic [3:0]  dot_sr;
    // one-hot tick position inside the current half phase
    logic [15:0] pos_sr;
    logic [3:0]  pos_enc;

    // reset lands on the first tick of a phi-low half
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_sr <= 32'hFFFF_0000;
            dot_sr <= 4'b0001;
            pos_sr <= 16'h0001;
        end else begin
            phi_sr <= {phi_sr[0], phi_sr[31:1]};
            dot_sr <= {dot_sr[2:0], dot_sr[3]};
            pos_sr <= {pos_sr[14:0], pos_sr[15]};
        end
    end

    // one-hot to binary
    always_comb begin
        pos_enc = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (pos_sr[i]) begin
                pos_enc = 4'(i);
            end
        end
    end

    assign phase_o.clk_phi   = phi_sr[0];
    assign phase_o.dot_last  = dot_sr[3];
    assign phase_o.phase_pos = pos_enc;

    a_pos_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
        $onehot(pos_sr))
        else $error("half-phase position lost its single bit");

endmodule

// File: rtl/vic_pkg.sv
package vic_pkg;

    // ----------------------------------------
    // chip identity
    // ----------------------------------------
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6569     = 2'd1,
        CHIP_6567R56A = 2'd2,
        CHIP_UNUSED   = 2'd3
    } chip_t;

    // last pixel of a line and last line of a frame
    typedef struct packed {
        logic [9:0] raster_x_max;
        logic [8:0] raster_y_max;
    } chip_limits_t;

    function automatic chip_limits_t chip_limits(chip_t chip);
        chip_limits_t lim;
        case (chip)
            // 520 pixels, 263 lines
            CHIP_6567R8:   lim = '{raster_x_max: 10'd519, raster_y_max: 9'd262};
            // 512 pixels, 262 lines
            CHIP_6567R56A: lim = '{raster_x_max: 10'd511, raster_y_max: 9'd261};
            // pal part, unused code falls back to it
            default:       lim = '{raster_x_max: 10'd503, raster_y_max: 9'd311};
        endcase
        return lim;
    endfunction

    // ----------------------------------------
    // timing
    // ----------------------------------------
    typedef struct packed {
        logic [9:0] raster_x;
        logic [6:0] cycle_num;
        logic [8:0] raster_line;
        logic [8:0] raster_line_d;
    } raster_pos_t;

    typedef struct packed {
        logic       clk_phi;
        logic       dot_last;
        logic [3:0] phase_pos;
    } phase_t;

    // half-phase tick where cpu data is sampled
    localparam logic [3:0] PHASE_DAV = 4'd11;
    // half-phase tick of the raster compare
    localparam logic [3:0] PHASE_IRQ = 4'd8;

    // ----------------------------------------
    // cpu bus and registers
    // ----------------------------------------
    typedef struct packed {
        logic       ce_n;
        logic       rw;
        logic [5:0] addr;
        logic [7:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic [2:0] yscroll;
        logic       rsel;
        logic       den;
        logic       bmm;
        logic       ecm;
        logic [8:0] raster_cmp;
        logic [3:0] border;
        logic       erst;
    } vic_ctrl_t;

    localparam logic [5:0] REG_CTRL1  = 6'h11;
    localparam logic [5:0] REG_RASTER = 6'h12;
    localparam logic [5:0] REG_IRQ    = 6'h19;
    localparam logic [5:0] REG_IRQ_EN = 6'h1A;
    localparam logic [5:0] REG_BORDER = 6'h20;

    // ----------------------------------------
    // badline and ba window
    // ----------------------------------------
    localparam logic [8:0] BADLINE_FIRST = 9'd48;
    localparam logic [8:0] BADLINE_LAST  = 9'd248;
    localparam logic [6:0] BA_CHAR_FIRST_CYCLE = 7'd11;
    localparam logic [6:0] BA_CHAR_LAST_CYCLE  = 7'd53;

endpackage
